// File: logic/apb_pkg.sv
// ==========================================================
// APB bus widths and request/response structs for the timer
// Import into any block that sits on the peripheral bus
// ==========================================================

package apb_pkg;

   localparam int unsigned APB_AW = 12; // Byte address bits seen by the slave
   localparam int unsigned APB_DW = 32; // Read and write data bits

   // Master to slave, one bundle per transfer
   typedef struct packed {
      logic              psel;    // Slave selected
      logic              penable; // Second (access) cycle of the transfer
      logic              pwrite;  // 1 = write, 0 = read
      logic [APB_AW-1:0] paddr;   // Byte offset into the register map
      logic [APB_DW-1:0] pwdata;  // Write payload
   } apb_req_t;

   // Slave to master
   typedef struct packed {
      logic [APB_DW-1:0] prdata;  // Read data, valid in the access cycle
      logic              pready;  // Tied high, zero wait states
      logic              pslverr; // Unmapped offset
   } apb_rsp_t;

endpackage : apb_pkg

// File: logic/timer_pkg.sv
// ==========================================================
// Register map, channel configuration and compare actions
// shared by the timer register file, prescalers and counters
// ==========================================================

package timer_pkg;

   localparam int unsigned CNT_W   = 32; // Counter and compare width
   localparam int unsigned CFG_W   = 16; // Implemented CFG register bits
   localparam int unsigned PRESC_W = 8;  // Prescaler divider width

   // Word offsets of the register map
   typedef enum logic [apb_pkg::APB_AW-1:0] {
      CFG_LO = 12'h000, // Lo channel configuration
      CFG_HI = 12'h004, // Hi channel configuration
      CNT_LO = 12'h008, // Lo counter value, write loads
      CNT_HI = 12'h00C, // Hi counter value, write loads
      CMP_LO = 12'h010, // Lo compare value
      CMP_HI = 12'h014  // Hi compare value
   } timer_reg_e;

   // What the counter does once it hits its compare value
   typedef enum logic {
      CMP_CLEAR = 1'b0, // Back to zero, periodic mode
      CMP_KEEP  = 1'b1  // Free running, match is only an event
   } cmp_action_e;

   // One channel's CFG register, declared MSB first
   typedef struct packed {
      logic [PRESC_W-1:0] presc_val; // Bits 15:8, divide by presc_val+1
      logic [1:0]         rsvd;      // Bits 7:6, stored and read back
      logic               cascade;   // Bit 5, lo channel only
      cmp_action_e        action;    // Bit 4
      logic               presc_en;  // Bit 3
      logic               clear;     // Bit 2, write pulse, reads as 0
      logic               irq_en;    // Bit 1
      logic               enable;    // Bit 0
   } timer_cfg_t;

endpackage : timer_pkg

// File: logic/apb_timer_regs.sv
// ==========================================================
// APB slave and register file of the timer subsystem. Holds
// the CFG and CMP registers, reads back the live counters
// ==========================================================

`timescale 1ns/1ps

module apb_timer_regs (
   input  logic                         ref_clk_i,  // System clock
   input  logic                         reset_i,    // Sync, active high
   input  apb_pkg::apb_req_t            apb_req_i,  // Bus request
   output apb_pkg::apb_rsp_t            apb_rsp_o,  // Bus response
   output timer_pkg::timer_cfg_t        cfg_lo_o,   // Lo channel setup, clear is a pulse
   output timer_pkg::timer_cfg_t        cfg_hi_o,   // Hi channel setup, clear is a pulse
   output logic [timer_pkg::CNT_W-1:0]  cmp_lo_o,   // Lo compare value
   output logic [timer_pkg::CNT_W-1:0]  cmp_hi_o,   // Hi compare value
   output logic                         load_lo_o,  // Load strobe for lo counter
   output logic                         load_hi_o,  // Load strobe for hi counter
   output logic [timer_pkg::CNT_W-1:0]  load_val_o, // Value to load, shared
   input  logic [timer_pkg::CNT_W-1:0]  cnt_lo_i,   // Lo counter readback
   input  logic [timer_pkg::CNT_W-1:0]  cnt_hi_i    // Hi counter readback
);

   import apb_pkg::*;
   import timer_pkg::*;

   logic              access;    // Access phase of a transfer
   logic              addr_ok;   // Offset is in the register map
   logic              wr_en;     // Mapped write in access phase
   timer_reg_e        reg_sel;   // Decoded offset
   timer_cfg_t        cfg_raw;   // CFG view of the write data
   timer_cfg_t        cfg_wdata; // Same, with the clear pulse bit dropped
   timer_cfg_t        cfg_lo_q;
   timer_cfg_t        cfg_hi_q;
   logic [CNT_W-1:0]  cmp_lo_q;
   logic [CNT_W-1:0]  cmp_hi_q;
   logic [APB_DW-1:0] rdata;

   assign access  = apb_req_i.psel & apb_req_i.penable;
   assign wr_en   = access & apb_req_i.pwrite & addr_ok;
   assign reg_sel = timer_reg_e'(apb_req_i.paddr);
   assign cfg_raw = timer_cfg_t'(apb_req_i.pwdata[CFG_W-1:0]);

   always_comb begin
      cfg_wdata       = cfg_raw;
      cfg_wdata.clear = 1'b0; // Never stored
   end

   // Address decode and read mux, combinational from current state
   always_comb begin
      addr_ok = 1'b1;
      rdata   = '0;
      case (reg_sel)
         CFG_LO:  rdata = {{(APB_DW-CFG_W){1'b0}}, cfg_lo_q};
         CFG_HI:  rdata = {{(APB_DW-CFG_W){1'b0}}, cfg_hi_q};
         CNT_LO:  rdata = cnt_lo_i; // Live count
         CNT_HI:  rdata = cnt_hi_i;
         CMP_LO:  rdata = cmp_lo_q;
         CMP_HI:  rdata = cmp_hi_q;
         default: addr_ok = 1'b0;   // Unmapped, flagged as pslverr
      endcase
   end

   // Register writes land on the edge that closes the access cycle
   always_ff @(posedge ref_clk_i) begin
      if (reset_i) begin
         cfg_lo_q <= '0;
         cfg_hi_q <= '0;
         cmp_lo_q <= '0;
         cmp_hi_q <= '0;
      end else if (wr_en) begin
         case (reg_sel)
            CFG_LO:  cfg_lo_q <= cfg_wdata;
            CFG_HI:  cfg_hi_q <= cfg_wdata;
            CMP_LO:  cmp_lo_q <= apb_req_i.pwdata[CNT_W-1:0];
            CMP_HI:  cmp_hi_q <= apb_req_i.pwdata[CNT_W-1:0];
            default: ; // CNT writes leave as load strobes
         endcase
      end
   end

   // Channel setup, clear bit replaced by the write pulse
   always_comb begin
      cfg_lo_o       = cfg_lo_q;
      cfg_lo_o.clear = wr_en & (reg_sel == CFG_LO) & cfg_raw.clear;
      cfg_hi_o       = cfg_hi_q;
      cfg_hi_o.clear = wr_en & (reg_sel == CFG_HI) & cfg_raw.clear;
   end

   assign cmp_lo_o   = cmp_lo_q;
   assign cmp_hi_o   = cmp_hi_q;
   // Counters take the value on the same edge as a register write
   assign load_lo_o  = wr_en & (reg_sel == CNT_LO);
   assign load_hi_o  = wr_en & (reg_sel == CNT_HI);
   assign load_val_o = apb_req_i.pwdata[CNT_W-1:0];

   assign apb_rsp_o.prdata  = rdata;
   assign apb_rsp_o.pready  = 1'b1;               // Zero wait states
   assign apb_rsp_o.pslverr = access & ~addr_ok;  // Only in the access cycle

   // One shared load value, so only one counter may take it per cycle
   a_single_load : assert property (@(posedge ref_clk_i) disable iff (reset_i)
      !(load_lo_o && load_hi_o));

endmodule : apb_timer_regs

// File: logic/timer_prescaler.sv
// ==========================================================
// Clock prescaler for one timer channel. Emits a tick every
// presc_val+1 cycles, or every cycle when bypassed
// ==========================================================

`timescale 1ns/1ps

module timer_prescaler (
   input  logic                  ref_clk_i, // System clock
   input  logic                  reset_i,   // Sync, active high
   input  timer_pkg::timer_cfg_t cfg_i,     // Channel setup
   output logic                  tick_o     // Count enable for the counter
);

   import timer_pkg::*;

   logic [PRESC_W-1:0] div_q;   // Cycles since the last tick
   logic               div_end; // Divider reached its terminal count

   // >= so a smaller presc_val written mid-count takes effect at once
   assign div_end = (div_q >= cfg_i.presc_val);

   always_ff @(posedge ref_clk_i) begin
      if (reset_i) begin
         div_q <= '0;
      end else if (!cfg_i.enable || cfg_i.clear || !cfg_i.presc_en) begin
         div_q <= '0; // Restart, first tick after presc_val+1 cycles
      end else if (div_end) begin
         div_q <= '0;
      end else begin
         div_q <= div_q + 1'b1;
      end
   end

   assign tick_o = cfg_i.enable & (~cfg_i.presc_en | div_end);

   // Disabled channel never counts
   a_no_tick_disabled : assert property (@(posedge ref_clk_i) disable iff (reset_i)
      !cfg_i.enable |-> !tick_o);

   // Divider restarts on enable, so no early tick with a real divide
   a_restart_on_enable : assert property (@(posedge ref_clk_i) disable iff (reset_i)
      $rose(cfg_i.enable) && cfg_i.presc_en && (cfg_i.presc_val != '0) |-> !tick_o);

endmodule : timer_prescaler

// File: logic/timer_counter.sv
// ==========================================================
// Counter of one timer channel. Counts on ticks, loads from
// the bus, raises irq on compare match and wrap on overflow
// ==========================================================

`timescale 1ns/1ps

module timer_counter (
   input  logic                         ref_clk_i,  // System clock
   input  logic                         reset_i,    // Synchronous active high reset
   input  timer_pkg::timer_cfg_t        cfg_i,      // Channel setup
   input  logic [timer_pkg::CNT_W-1:0]  cmp_i,      // Compare value
   input  logic                         tick_i,     // Count enable
   input  logic                         load_i,     // Bus write to CNT
   input  logic [timer_pkg::CNT_W-1:0]  load_val_i, // Value to load
   output logic [timer_pkg::CNT_W-1:0]  cnt_o,      // Current count
   output logic                         wrap_o,     // One-cycle pulse from all ones to zero
   output logic                         irq_o       // One-cycle compare match event
);

   import timer_pkg::*;

   logic [CNT_W-1:0] cnt_q;
   logic             count_en; // Tick not overridden by load or clear
   logic             match;    // Counting step that hits the compare value
   logic             irq_q;
   logic             wrap_q;

   // Priority is load, then clear, then tick
   assign count_en = tick_i & ~load_i & ~cfg_i.clear;
   assign match    = count_en & (cnt_q == cmp_i);

   always_ff @(posedge ref_clk_i) begin
      if (reset_i) begin
         cnt_q <= '0;
      end else if (load_i) begin
         cnt_q <= load_val_i;
      end else if (cfg_i.clear) begin
         cnt_q <= '0;
      end else if (match && (cfg_i.action == CMP_CLEAR)) begin
         cnt_q <= '0; // Periodic mode restarts
      end else if (count_en) begin
         cnt_q <= cnt_q + 1'b1; // Wraps naturally past all ones
      end
   end

   // Event pulses line up with the count update they belong to
   always_ff @(posedge ref_clk_i) begin
      if (reset_i) begin
         irq_q  <= 1'b0;
         wrap_q <= 1'b0;
      end else begin
         irq_q  <= match & cfg_i.irq_en;
         wrap_q <= count_en & (&cnt_q); // Step out of all ones
      end
   end

   assign cnt_o  = cnt_q;
   assign wrap_o = wrap_q;
   assign irq_o  = irq_q;

   // Back-to-back irq only while a periodic count sits at zero
   a_irq_pulse : assert property (@(posedge ref_clk_i) disable iff (reset_i)
      irq_o |=> !irq_o || $past(cnt_q == '0));

   // Masked channel stays silent
   a_irq_masked : assert property (@(posedge ref_clk_i) disable iff (reset_i)
      irq_o |-> $past(cfg_i.irq_en));

endmodule : timer_counter

// File: logic/apb_timer_ss.sv
// ==========================================================
// APB timer subsystem top. Register file, lo and hi channels
// each with prescaler and counter, optional 64-bit cascade
// ==========================================================

`timescale 1ns/1ps

module apb_timer_ss (
   input  logic              ref_clk_i, // System clock
   input  logic              reset_i,   // Sync, active high
   input  apb_pkg::apb_req_t apb_req_i, // Processor bus request
   output apb_pkg::apb_rsp_t apb_rsp_o, // Processor bus response
   output logic              irq_lo_o,  // Lo compare event
   output logic              irq_hi_o   // Hi compare event
);

   import timer_pkg::*;

   timer_cfg_t       cfg_lo;
   timer_cfg_t       cfg_hi;
   logic [CNT_W-1:0] cmp_lo;
   logic [CNT_W-1:0] cmp_hi;
   logic [CNT_W-1:0] cnt_lo;
   logic [CNT_W-1:0] cnt_hi;
   logic [CNT_W-1:0] load_val;
   logic             load_lo;
   logic             load_hi;
   logic             tick_lo;
   logic             tick_hi;    // From the hi prescaler
   logic             tick_hi_en; // What actually advances the hi counter
   logic             wrap_lo;

   apb_timer_regs regs (
      .ref_clk_i  (ref_clk_i),
      .reset_i    (reset_i),
      .apb_req_i  (apb_req_i),
      .apb_rsp_o  (apb_rsp_o),
      .cfg_lo_o   (cfg_lo),
      .cfg_hi_o   (cfg_hi),
      .cmp_lo_o   (cmp_lo),
      .cmp_hi_o   (cmp_hi),
      .load_lo_o  (load_lo),
      .load_hi_o  (load_hi),
      .load_val_o (load_val),
      .cnt_lo_i   (cnt_lo),
      .cnt_hi_i   (cnt_hi)
   );

   timer_prescaler prescaler_lo (
      .ref_clk_i (ref_clk_i),
      .reset_i   (reset_i),
      .cfg_i     (cfg_lo),
      .tick_o    (tick_lo)
   );

   timer_prescaler prescaler_hi (
      .ref_clk_i (ref_clk_i),
      .reset_i   (reset_i),
      .cfg_i     (cfg_hi),
      .tick_o    (tick_hi)
   );

   // 64-bit mode, hi advances once per lo overflow
   assign tick_hi_en = cfg_lo.cascade ? wrap_lo : tick_hi;

   timer_counter counter_lo (
      .ref_clk_i  (ref_clk_i),
      .reset_i    (reset_i),
      .cfg_i      (cfg_lo),
      .cmp_i      (cmp_lo),
      .tick_i     (tick_lo),
      .load_i     (load_lo),
      .load_val_i (load_val),
      .cnt_o      (cnt_lo),
      .wrap_o     (wrap_lo),
      .irq_o      (irq_lo_o)
   );

   timer_counter counter_hi (
      .ref_clk_i  (ref_clk_i),
      .reset_i    (reset_i),
      .cfg_i      (cfg_hi),
      .cmp_i      (cmp_hi),
      .tick_i     (tick_hi_en),
      .load_i     (load_hi),
      .load_val_i (load_val),
      .cnt_o      (cnt_hi),
      .wrap_o     (), // Top of the 64-bit chain, overflow unused
      .irq_o      (irq_hi_o)
   );

endmodule : apb_timer_ss

// File: test/tb_apb_timer_ss.sv
// ==========================================================
// Self-checking testbench for the APB timer subsystem. Runs
// register, period, hold, cascade and masking tests on dut0
// ==========================================================

`timescale 1ns/1ps

module tb_apb_timer_ss;

   import apb_pkg::*;
   import timer_pkg::*;

   localparam int MAX_CYCLES = 20000; // Tests need well under 2000 cycles

   logic        ref_clk_i;
   logic        reset_i;
   apb_req_t    apb_req;
   apb_rsp_t    apb_rsp;
   logic        irq_lo_o;
   logic        irq_hi_o;

   int          errors      = 0;
   int          checks      = 0;
   int          cycle_count = 0;
   logic [31:0] rng_state   = 32'hc226_a5ba;
   logic        irq_en_lo   = 1'b0; // Expected CFG_LO.irq_en, tracks bus writes
   logic        irq_en_hi   = 1'b0; // Same for CFG_HI

   apb_timer_ss dut0 (
      .ref_clk_i (ref_clk_i),
      .reset_i   (reset_i),
      .apb_req_i (apb_req),
      .apb_rsp_o (apb_rsp),
      .irq_lo_o  (irq_lo_o),
      .irq_hi_o  (irq_hi_o)
   );

   initial begin
      ref_clk_i = 1'b0;
      forever #4 ref_clk_i = ~ref_clk_i; // 8 ns period
   end

   // Watchdog
   always @(posedge ref_clk_i) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= MAX_CYCLES) begin
         $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
         $display("Checks: %0d, errors: %0d", checks, errors);
         $display("Simulation failed");
         $finish;
      end
   end

   function automatic logic [31:0] next_random();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223; // Numerical Recipes LCG
      return rng_state;
   endfunction

   // Six word offsets from 0x000 to 0x014
   function automatic logic is_mapped(input logic [APB_AW-1:0] addr);
      return (addr[1:0] == 2'b00) && (addr <= 12'h014);
   endfunction

   a_pready : assert property (@(posedge ref_clk_i) disable iff (reset_i) apb_rsp.pready)
      else begin
         errors++;
         $display("FAILED at %0t: pready expected 1 got 0", $time);
      end

   a_pslverr : assert property (@(posedge ref_clk_i) disable iff (reset_i)
      apb_rsp.pslverr == (apb_req.psel && apb_req.penable && !is_mapped(apb_req.paddr)))
      else begin
         errors++;
         $display("FAILED at %0t: pslverr expected %b got %b", $time,
                  !$sampled(apb_rsp.pslverr), $sampled(apb_rsp.pslverr));
      end

   // Pulse follows the match cycle, so irq_en is judged one cycle back
   a_irq_lo_masked : assert property (@(posedge ref_clk_i) disable iff (reset_i)
      irq_lo_o |-> $past(irq_en_lo))
      else begin
         errors++;
         $display("FAILED at %0t: irq_lo_o expected 0 got 1", $time);
      end

   a_irq_hi_masked : assert property (@(posedge ref_clk_i) disable iff (reset_i)
      irq_hi_o |-> $past(irq_en_hi))
      else begin
         errors++;
         $display("FAILED at %0t: irq_hi_o expected 0 got 1", $time);
      end

   task automatic check_equal(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      checks++;
      assert (act === exp) else begin
         errors++;
         $display("FAILED at %0t: %s expected 0x%08h got 0x%08h", $time, name, exp, act);
      end
   endtask

   task automatic check_in_range(input string name, input logic [31:0] lo,
                                 input logic [31:0] hi, input logic [31:0] act);
      checks++;
      assert (act >= lo && act <= hi) else begin
         errors++;
         $display("FAILED at %0t: %s expected 0x%08h..0x%08h got 0x%08h", $time, name,
                  lo, hi, act);
      end
   endtask

   task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data);
      timer_cfg_t cfg_view;
      cfg_view = timer_cfg_t'(data[CFG_W-1:0]);
      @(posedge ref_clk_i);
      apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
      @(posedge ref_clk_i);
      apb_req.penable <= 1'b1;                                // Access phase
      @(posedge ref_clk_i);                                   // Register takes the write
      apb_req <= '0;
      if (addr == CFG_LO) irq_en_lo <= cfg_view.irq_en;
      if (addr == CFG_HI) irq_en_hi <= cfg_view.irq_en;
   endtask

   task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [APB_DW-1:0] data,
                           output logic slverr);
      @(posedge ref_clk_i);
      apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: '0};
      @(posedge ref_clk_i);
      apb_req.penable <= 1'b1;
      @(negedge ref_clk_i);                                   // Mid access cycle, settled
      data   = apb_rsp.prdata;
      slverr = apb_rsp.pslverr;
      @(posedge ref_clk_i);
      apb_req <= '0;
   endtask

   task automatic read_expect(input logic [APB_AW-1:0] addr, input string name,
                              input logic [31:0] exp);
      logic [31:0] data;
      logic        slverr;
      apb_read(addr, data, slverr);
      check_equal(name, exp, data);
   endtask

   task automatic wait_irq(input logic hi, input int max_cycles, output logic seen);
      int waited;
      waited = 0;
      seen   = 1'b0;
      while (!seen && waited < max_cycles) begin
         @(negedge ref_clk_i);
         waited++;
         seen = hi ? irq_hi_o : irq_lo_o;
      end
      if (!seen) begin
         errors++;
         $display("No pulse on irq_%s_o within %0d cycles", hi ? "hi" : "lo", max_cycles);
      end
   endtask

   initial begin
      logic [31:0] rnd;
      logic [31:0] rdata;
      logic [31:0] cnt_a;
      logic [31:0] cnt_b;
      logic        slverr;
      logic        seen;
      int          cmp_val;
      int          presc_val;
      int          period;
      int          t_prev;
      int          pulses;
      timer_cfg_t  cfg;

      $timeformat(-9, 0, " ns", 0);
      reset_i = 1'b1;
      apb_req = '0;
      repeat (8) @(posedge ref_clk_i);
      reset_i <= 1'b0;

      // Test 1, reset state, readback and decode
      @(negedge ref_clk_i);
      check_equal("irq_lo_o", 32'd0, irq_lo_o);
      check_equal("irq_hi_o", 32'd0, irq_hi_o);
      for (int i = 0; i < 6; i++) begin
         read_expect(12'(i * 4), $sformatf("reset value @0x%03h", i * 4), 32'd0);
      end
      rnd = next_random();
      apb_write(CMP_LO, rnd);
      read_expect(CMP_LO, "CMP_LO", rnd);
      rnd = next_random();
      apb_write(CMP_HI, rnd);
      read_expect(CMP_HI, "CMP_HI", rnd);
      rnd = next_random();
      apb_write(CFG_LO, rnd);
      read_expect(CFG_LO, "CFG_LO", rnd & 32'h0000_fffb); // 16 bits, clear reads 0
      rnd = next_random();
      apb_write(CFG_HI, rnd);
      read_expect(CFG_HI, "CFG_HI", rnd & 32'h0000_fffb);
      apb_read(12'h020, rdata, slverr);
      check_equal("pslverr @0x020", 32'd1, slverr);
      apb_read(CMP_HI, rdata, slverr);
      check_equal("pslverr @CMP_HI", 32'd0, slverr);
      apb_write(CFG_LO, 32'd0);                             // Stop whatever random CFG started
      apb_write(CFG_HI, 32'd0);
      apb_write(CNT_LO, 32'd0);
      apb_write(CNT_HI, 32'd0);

      // Test 2, periodic irq with prescaler
      cmp_val   = int'(next_random() >> 28);                // 0..15
      presc_val = int'(next_random() >> 29);                // 0..7
      period    = (cmp_val + 1) * (presc_val + 1);
      cfg           = '0;
      cfg.enable    = 1'b1;
      cfg.irq_en    = 1'b1;
      cfg.presc_en  = 1'b1;
      cfg.clear     = 1'b1;
      cfg.action    = CMP_CLEAR;
      cfg.presc_val = 8'(presc_val);
      apb_write(CMP_LO, cmp_val);
      apb_write(CFG_LO, {16'h0, cfg});
      wait_irq(1'b0, 2 * period + 8, seen);
      t_prev = cycle_count;
      repeat (3) begin
         wait_irq(1'b0, period + 8, seen);
         if (seen) check_equal("irq_lo_o period", period, cycle_count - t_prev);
         t_prev = cycle_count;
      end

      // Test 3, disabled counter holds, CNT write loads
      apb_write(CFG_LO, 32'd0);
      apb_read(CNT_LO, cnt_a, slverr);
      repeat (16) @(posedge ref_clk_i);
      apb_read(CNT_LO, cnt_b, slverr);
      check_equal("CNT_LO held", cnt_a, cnt_b);
      rnd = next_random();
      apb_write(CNT_LO, rnd);
      read_expect(CNT_LO, "CNT_LO loaded", rnd);

      // Test 4, 64-bit cascade, hi steps once on lo wrap
      apb_write(CMP_HI, 32'd1);
      apb_write(CNT_HI, 32'd1);                             // Match on the first wrap step
      cfg        = '0;
      cfg.irq_en = 1'b1;
      cfg.action = CMP_KEEP;
      apb_write(CFG_HI, {16'h0, cfg});                      // Hi prescaler stays off
      apb_write(CNT_LO, 32'hffff_fffd);
      read_expect(CNT_HI, "CNT_HI before wrap", 32'd1);
      cfg         = '0;
      cfg.enable  = 1'b1;
      cfg.action  = CMP_KEEP;
      cfg.cascade = 1'b1;
      apb_write(CFG_LO, {16'h0, cfg});
      wait_irq(1'b1, 16, seen);
      read_expect(CNT_HI, "CNT_HI after wrap", 32'd2);
      apb_read(CNT_LO, rdata, slverr);
      check_in_range("CNT_LO after wrap", 32'd0, 32'h0000_00ff, rdata);

      // Test 5, free running past compare with irq masked
      apb_write(CFG_LO, 32'd0);
      apb_write(CFG_HI, 32'd0);
      apb_write(CNT_LO, 32'd0);
      cmp_val = int'(next_random() >> 28);
      apb_write(CMP_LO, cmp_val);
      cfg        = '0;
      cfg.enable = 1'b1;
      cfg.action = CMP_KEEP;
      apb_write(CFG_LO, {16'h0, cfg});
      pulses = 0;
      repeat (cmp_val + 24) begin
         @(negedge ref_clk_i);
         if (irq_lo_o || irq_hi_o) pulses++;
      end
      check_equal("irq pulses while masked", 32'd0, pulses);
      apb_read(CNT_LO, rdata, slverr);
      check_in_range("CNT_LO past compare", cmp_val + 1, 32'h0000_ffff, rdata);

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule : tb_apb_timer_ss

// File: tb.f
logic/apb_pkg.sv
logic/timer_pkg.sv
logic/apb_timer_regs.sv
logic/timer_prescaler.sv
logic/timer_counter.sv
logic/apb_timer_ss.sv
test/tb_apb_timer_ss.sv

// File: Bender.yml
package:
  name: apb_timer_ss

dependencies: {}

sources:
  # Packages first, apb_pkg is used by timer_pkg
  - logic/apb_pkg.sv
  - logic/timer_pkg.sv
  # Register file and channel blocks
  - logic/apb_timer_regs.sv
  - logic/timer_prescaler.sv
  - logic/timer_counter.sv
  # Subsystem top level
  - logic/apb_timer_ss.sv
  # Testbench
  - target: test
    files:
      - test/tb_apb_timer_ss.sv
